// ==== Bender.yml ====
package:
  name: scratch_mem

sources:
  # Shared package and interface
  - common/scratch_mem_pkg.sv
  - common/mem_port_if.sv
  # Pipeline stages and array
  - hdl/cmd_decoder.sv
  - memory_block_generator/memory_block_generator.sv
  - memory_block_generator/memory_block_generator_sva.sv
  - hdl/read_result.sv
  - hdl/scratch_mem_top.sv
  # Testbench
  - target: simulation
    files:
      - dv/scratch_mem_tb.sv

// ==== common/mem_port_if.sv ====
// Request and array bundle between the three stages; douta is combinational from the array
`timescale 1ns/1ns

interface mem_port_if #(
  parameter int DATA_W = 3,
  parameter int ADDR_W = 13
) ();

  // Decoded request, one cycle after the command
  logic              req_valid;
  logic              req_err;

  // Array write strobe, byte address and write data
  logic              wea;
  logic [ADDR_W-1:0] addra;
  logic [DATA_W-1:0] dina;

  // Array read data, equal to dina while writing
  logic [DATA_W-1:0] douta;

  modport decoder (
    output req_valid,
    output req_err,
    output wea,
    output addra,
    output dina
  );

  modport memory (
    input  wea,
    input  addra,
    input  dina,
    output douta
  );

  modport result (
    input  req_valid,
    input  req_err,
    input  douta
  );

endinterface

// ==== common/scratch_mem_pkg.sv ====
// Shared opcode and default sizes; widths are defaults only and every module can be resized
package scratch_mem_pkg;

  // Command opcode as seen on the top-level cmd_op port
  typedef enum logic [1:0] {
    OP_NOP   = 2'd0,
    OP_READ  = 2'd1,
    OP_WRITE = 2'd2,
    OP_RSVD  = 2'd3
  } op_e;

  // Width of one stored word
  parameter int DATA_W_DEF = 3;

  // Byte address width whose bit 0 is dropped to form the word index
  parameter int ADDR_W_DEF = 13;

  // Number of words addressed by an address of the given width
  function automatic int unsigned word_depth(input int unsigned addr_w);
    return 32'd1 << (addr_w - 1);
  endfunction

  // Words in the array at the default address width
  parameter int DEPTH_DEF = word_depth(ADDR_W_DEF);

endpackage

// ==== dv/scratch_mem_tb.sv ====
// Default widths only; reads only words it has written, since the array is not reset
`timescale 1ns/1ns

module scratch_mem_tb import scratch_mem_pkg::*;;

  localparam int DATA_W = DATA_W_DEF;
  localparam int ADDR_W = ADDR_W_DEF;
  localparam int WORD_W = ADDR_W - 1;
  localparam int DEPTH  = 1 << WORD_W;

  typedef struct packed {
    logic              err;
    logic [DATA_W-1:0] data;
  } rsp_t;

  logic              dut;
  logic              rst_n;
  logic              cmd_valid;
  op_e               cmd_op;
  logic [ADDR_W-1:0] cmd_addr;
  logic [DATA_W-1:0] cmd_data;
  logic              rsp_valid;
  logic              rsp_err;
  logic [DATA_W-1:0] rsp_data;

  // Shadow of the array and expected responses still in flight
  logic [DATA_W-1:0] shadow [DEPTH];
  rsp_t              exp_q [$:1];
  logic              pend;
  logic              exp_valid;
  logic              exp_err;
  logic [DATA_W-1:0] exp_data;

  int  errors;
  int  timeouts;
  bit  timed_out;

  scratch_mem_top #(
    .DATA_W(DATA_W),
    .ADDR_W(ADDR_W)
  ) scratch_mem_top_i (
    .dut      (dut),
    .rst_n    (rst_n),
    .cmd_valid(cmd_valid),
    .cmd_op   (cmd_op),
    .cmd_addr (cmd_addr),
    .cmd_data (cmd_data),
    .rsp_valid(rsp_valid),
    .rsp_err  (rsp_err),
    .rsp_data (rsp_data)
  );

  initial dut = 1'b0;
  always #50 dut = ~dut;

  // Expected response is set up one edge after the command, so it lines up with rsp_valid
  always @(posedge dut or negedge rst_n) begin
    rsp_t item;
    if (!rst_n) begin
      exp_q.delete();
      pend      <= 1'b0;
      exp_valid <= 1'b0;
      exp_err   <= 1'b0;
      exp_data  <= '0;
    end else begin
      if (pend) begin
        item = exp_q.pop_front();
        exp_valid <= 1'b1;
        exp_err   <= item.err;
        exp_data  <= item.data;
      end else begin
        exp_valid <= 1'b0;
        exp_err   <= 1'b0;
      end
      pend <= cmd_valid && (cmd_op != OP_NOP);
      if (cmd_valid) begin
        case (cmd_op)
          OP_WRITE: begin
            shadow[cmd_addr[ADDR_W-1:1]] = cmd_data;
            exp_q.push_back(rsp_t'{err: 1'b0, data: cmd_data});
          end
          OP_READ:  exp_q.push_back(rsp_t'{err: 1'b0, data: shadow[cmd_addr[ADDR_W-1:1]]});
          OP_RSVD:  exp_q.push_back(rsp_t'{err: 1'b1, data: '0});
          default: ;
        endcase
      end
    end
  end

  a_rsp_valid: assert property (@(posedge dut) disable iff (!rst_n) rsp_valid === exp_valid)
    else begin
      errors++;
      $display("[ERROR] %0t ns: rsp_valid %b, expected %b", $time,
               $sampled(rsp_valid), $sampled(exp_valid));
    end

  a_rsp_err: assert property (
    @(posedge dut) disable iff (!rst_n) rsp_err === (exp_valid && exp_err)
  ) else begin
    errors++;
    $display("[ERROR] %0t ns: rsp_err %b, expected %b", $time,
             $sampled(rsp_err), $sampled(exp_valid && exp_err));
  end

  a_rsp_data: assert property (
    @(posedge dut) disable iff (!rst_n) exp_valid |-> (rsp_data === exp_data)
  ) else begin
    errors++;
    $display("[ERROR] %0t ns: rsp_data %0h, expected %0h", $time,
             $sampled(rsp_data), $sampled(exp_data));
  end

  // Error responses carry no data
  a_err_no_data: assert property (
    @(posedge dut) disable iff (!rst_n) (rsp_valid && rsp_err) |-> (rsp_data === '0)
  ) else begin
    errors++;
    $display("[ERROR] %0t ns: error response with data %0h", $time, $sampled(rsp_data));
  end

  task automatic issue_cmd(input logic valid, input op_e op,
                           input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    @(posedge dut);
    #5;
    cmd_valid = valid;
    cmd_op    = op;
    cmd_addr  = addr;
    cmd_data  = data;
  endtask

  task automatic idle_cycles(input int n);
    for (int i = 0; i < n; i++) begin
      issue_cmd(1'b0, OP_NOP, '0, '0);
    end
  endtask

  function automatic bit pipeline_busy();
    return pend || exp_valid || rsp_valid || (exp_q.size() != 0);
  endfunction

  task automatic wait_drain(input int limit, output bit late);
    int cnt;
    cnt = 0;
    while (pipeline_busy() && cnt < limit) begin
      @(posedge dut);
      #1;
      cnt++;
    end
    late = pipeline_busy();
  endtask

  initial begin
    rst_n     = 1'b1;
    cmd_valid = 1'b0;
    cmd_op    = OP_NOP;
    cmd_addr  = '0;
    cmd_data  = '0;
    errors    = 0;
    timeouts  = 0;
    void'($urandom(32'h6469_85de));
    #1;
    rst_n = 1'b0;
    for (int i = 0; i < 10; i++) begin
      @(posedge dut);
    end
    #5;
    rst_n = 1'b1;

    // Quiet start, NOPs and an unstrobed opcode
    idle_cycles(3);
    issue_cmd(1'b1, OP_NOP, 13'h0004, 3'd5);
    issue_cmd(1'b1, OP_NOP, 13'h0006, 3'd1);
    issue_cmd(1'b0, OP_READ, 13'h0000, 3'd0);
    issue_cmd(1'b0, OP_RSVD, 13'h0002, 3'd0);

    // Writes at both ends, then reads through the paired address
    issue_cmd(1'b1, OP_WRITE, 13'h0000, 3'd5);
    issue_cmd(1'b1, OP_WRITE, 13'h1fff, 3'd2);
    issue_cmd(1'b1, OP_READ,  13'h0001, 3'd0);
    issue_cmd(1'b1, OP_READ,  13'h1ffe, 3'd0);
    issue_cmd(1'b1, OP_READ,  13'h0000, 3'd0);
    issue_cmd(1'b1, OP_READ,  13'h1fff, 3'd0);
    issue_cmd(1'b1, OP_WRITE, 13'h0020, 3'd3);
    issue_cmd(1'b1, OP_WRITE, 13'h0021, 3'd6);
    idle_cycles(1);
    issue_cmd(1'b1, OP_READ,  13'h0020, 3'd0);

    // Read right behind a write to the same word
    issue_cmd(1'b1, OP_WRITE, 13'h0040, 3'd1);
    issue_cmd(1'b1, OP_READ,  13'h0041, 3'd0);
    issue_cmd(1'b1, OP_WRITE, 13'h0040, 3'd7);
    issue_cmd(1'b1, OP_READ,  13'h0040, 3'd0);

    // Reserved opcode leaves the word alone
    issue_cmd(1'b1, OP_RSVD,  13'h0040, 3'd4);
    issue_cmd(1'b1, OP_READ,  13'h0040, 3'd0);
    issue_cmd(1'b1, OP_RSVD,  13'h0100, 3'd2);
    idle_cycles(2);

    // Fill the words used by the random mix
    for (int w = 0; w < 16; w++) begin
      issue_cmd(1'b1, OP_WRITE, ADDR_W'(w << 1), DATA_W'($urandom));
    end
    for (int i = 0; i < 200; i++) begin
      issue_cmd($urandom_range(0, 7) != 0, op_e'($urandom_range(0, 3)),
                ADDR_W'(($urandom_range(0, 15) << 1) | $urandom_range(0, 1)),
                DATA_W'($urandom));
    end
    idle_cycles(2);

    wait_drain(20, timed_out);
    if (timed_out) begin
      timeouts++;
      $display("Responses still pending after the drain limit of 20 cycles");
    end
    $display("Checks done: %0d value errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
common/scratch_mem_pkg.sv
common/mem_port_if.sv
hdl/cmd_decoder.sv
memory_block_generator/memory_block_generator.sv
memory_block_generator/memory_block_generator_sva.sv
hdl/read_result.sv
hdl/scratch_mem_top.sv
dv/scratch_mem_tb.sv

// ==== hdl/cmd_decoder.sv ====
// Decode stage; every command is accepted and NOP produces no request, address and data unreset
`timescale 1ns/1ns

module cmd_decoder import scratch_mem_pkg::*; #(
  parameter int DATA_W = DATA_W_DEF,
  parameter int ADDR_W = ADDR_W_DEF
) (
  input  logic              dut,
  input  logic              rst_n,
  input  logic              cmd_valid,
  input  op_e               cmd_op,
  input  logic [ADDR_W-1:0] cmd_addr,
  input  logic [DATA_W-1:0] cmd_data,
  mem_port_if.decoder       port
);

  logic is_req;
  logic is_write;
  logic is_rsvd;

  // Only a strobed command counts
  assign is_req   = cmd_valid && (cmd_op != OP_NOP);
  assign is_write = cmd_valid && (cmd_op == OP_WRITE);
  assign is_rsvd  = cmd_valid && (cmd_op == OP_RSVD);

  // Control flags of the request
  always_ff @(posedge dut or negedge rst_n) begin
    if (!rst_n) begin
      port.req_valid <= 1'b0;
      port.req_err   <= 1'b0;
      port.wea       <= 1'b0;
    end else begin
      port.req_valid <= is_req;
      port.req_err   <= is_rsvd;
      // Reserved opcode never writes the array
      port.wea       <= is_write;
    end
  end

  // Address and data follow the command port every cycle
  always_ff @(posedge dut) begin
    port.addra <= cmd_addr;
    port.dina  <= cmd_data;
  end

  // A write is always a response-producing request
  a_wea_has_valid: assert property (
    @(posedge dut) disable iff (!rst_n)
    port.wea |-> port.req_valid
  ) else $error("wea without req_valid");

  // Write and error are exclusive
  a_wea_not_err: assert property (
    @(posedge dut) disable iff (!rst_n)
    !(port.wea && port.req_err)
  ) else $error("wea and req_err both high");

endmodule

// ==== hdl/read_result.sv ====
// Result stage; rsp_data holds its last value between responses and is zero for error responses
`timescale 1ns/1ns

module read_result import scratch_mem_pkg::*; #(
  parameter int DATA_W = DATA_W_DEF
) (
  input  logic              dut,
  input  logic              rst_n,
  mem_port_if.result        port,
  output logic              rsp_valid,
  output logic              rsp_err,
  output logic [DATA_W-1:0] rsp_data
);

  always_ff @(posedge dut or negedge rst_n) begin
    if (!rst_n) begin
      rsp_valid <= 1'b0;
      rsp_err   <= 1'b0;
      rsp_data  <= '0;
    end else begin
      rsp_valid <= port.req_valid;
      rsp_err   <= port.req_err;
      // Load only on a request so idle cycles leave the last answer
      if (port.req_valid) begin
        rsp_data <= port.req_err ? '0 : port.douta;
      end
    end
  end

  // An error is always reported as a response
  a_err_has_valid: assert property (
    @(posedge dut) disable iff (!rst_n)
    rsp_err |-> rsp_valid
  ) else $error("rsp_err without rsp_valid");

endmodule

// ==== hdl/scratch_mem_top.sv ====
// Scratch memory top; one response two cycles after each non-NOP command, no back-pressure
`timescale 1ns/1ns

module scratch_mem_top import scratch_mem_pkg::*; #(
  parameter int DATA_W = DATA_W_DEF,
  parameter int ADDR_W = ADDR_W_DEF
) (
  input  logic              dut,
  input  logic              rst_n,
  input  logic              cmd_valid,
  input  op_e               cmd_op,
  input  logic [ADDR_W-1:0] cmd_addr,
  input  logic [DATA_W-1:0] cmd_data,
  output logic              rsp_valid,
  output logic              rsp_err,
  output logic [DATA_W-1:0] rsp_data
);

  mem_port_if #(
    .DATA_W(DATA_W),
    .ADDR_W(ADDR_W)
  ) port_if ();

  cmd_decoder #(
    .DATA_W(DATA_W),
    .ADDR_W(ADDR_W)
  ) cmd_decoder_i (
    .dut      (dut),
    .rst_n    (rst_n),
    .cmd_valid(cmd_valid),
    .cmd_op   (cmd_op),
    .cmd_addr (cmd_addr),
    .cmd_data (cmd_data),
    .port     (port_if.decoder)
  );

  memory_block_generator #(
    .DATA_W(DATA_W),
    .ADDR_W(ADDR_W)
  ) memory_block_generator_i (
    .dut (dut),
    .port(port_if.memory)
  );

  read_result #(
    .DATA_W(DATA_W)
  ) read_result_i (
    .dut      (dut),
    .rst_n    (rst_n),
    .port     (port_if.result),
    .rsp_valid(rsp_valid),
    .rsp_err  (rsp_err),
    .rsp_data (rsp_data)
  );

  // Checker sees the array port, sized by the array's own parameters
  bind memory_block_generator memory_block_generator_sva #(
    .DATA_W(DATA_W),
    .ADDR_W(ADDR_W)
  ) memory_block_generator_sva_i (
    .mem_clk(dut),
    .port   (port)
  );

endmodule

// ==== memory_block_generator/memory_block_generator.sv ====
// Single-port word array; contents are not reset and a write shows on douta in the same cycle
`timescale 1ns/1ns

module memory_block_generator import scratch_mem_pkg::*; #(
  parameter int DATA_W = DATA_W_DEF,
  parameter int ADDR_W = ADDR_W_DEF
) (
  input  logic       dut,
  mem_port_if.memory port
);

  localparam int WORD_W = ADDR_W - 1;
  localparam int DEPTH  = word_depth(ADDR_W);

  logic [DATA_W-1:0] mem [DEPTH];
  logic [WORD_W-1:0] word_idx;

  // Byte address bit 0 selects nothing, both halves share a word
  assign word_idx = port.addra[ADDR_W-1:1];

  // Synchronous write
  always_ff @(posedge dut) begin
    if (port.wea) begin
      mem[word_idx] <= port.dina;
    end
  end

  // Write data bypasses the array while wea is high
  assign port.douta = port.wea ? port.dina : mem[word_idx];

  // A write needs a known address
  a_addr_known: assert property (
    @(posedge dut)
    port.wea |-> !$isunknown(port.addra)
  ) else $error("write with unknown address");

endmodule

// ==== memory_block_generator/memory_block_generator_sva.sv ====
// Checker bound into the array; unwritten words are X, so data checks apply only to written words
`timescale 1ns/1ns

module memory_block_generator_sva import scratch_mem_pkg::*; #(
  parameter int DATA_W = DATA_W_DEF,
  parameter int ADDR_W = ADDR_W_DEF
) (
  input  logic       mem_clk,
  mem_port_if.memory port
);

  localparam int WORD_W = ADDR_W - 1;
  localparam int DEPTH  = word_depth(ADDR_W);

  logic [WORD_W-1:0] word_idx;

  // Reference copy of the array and a flag per written word
  logic [DATA_W-1:0] ref_mem [DEPTH];
  bit                wrote   [DEPTH];

  assign word_idx = port.addra[ADDR_W-1:1];

  default clocking cb @(posedge mem_clk);
  endclocking

  always_ff @(posedge mem_clk) begin
    if (port.wea) begin
      ref_mem[word_idx] <= port.dina;
      wrote[word_idx]   <= 1'b1;
    end
  end

  // Bypass while writing
  a_bypass: assert property (port.wea |-> (port.douta == port.dina))
    else $error("bypass failure, douta differs from dina during write");

  // Strobe always known, address and data known when used
  a_no_x_wea: assert property (!$isunknown(port.wea))
    else $error("wea is X/Z");
  a_no_x_inputs: assert property (port.wea |-> !$isunknown({port.addra, port.dina}))
    else $error("write inputs contain X/Z");
  a_no_x_dout: assert property ((port.wea || wrote[word_idx]) |-> !$isunknown(port.douta))
    else $error("douta contains X/Z");

  // Read of a written word matches the model
  a_read_ok: assert property (
    (!port.wea && wrote[word_idx]) |-> (port.douta == ref_mem[word_idx])
  ) else $error("read data mismatch");

  // Next-cycle read-back of the same address
  a_wr_then_rd_same: assert property (
    port.wea ##1 (!port.wea && $stable(port.addra)) |-> (port.douta == $past(port.dina))
  ) else $error("write then read-back mismatch on same address");

  // No write for two samples and same address keeps douta still
  a_stable_read: assert property (
    (!port.wea ##1 (!port.wea && $stable(port.addra) && wrote[word_idx]))
      |-> $stable(port.douta)
  ) else $error("douta changed while idle and address stable");

  c_write:       cover property (port.wea);
  c_read:        cover property (!port.wea);
  c_wr_rd:       cover property (port.wea ##1 (!port.wea && $stable(port.addra)));
  c_addr_first:  cover property (port.wea && (port.addra == '0));
  c_addr_last:   cover property (port.wea && (port.addra == '1));
  c_lsb0_read:   cover property (!port.wea && (port.addra[0] == 1'b0));
  c_lsb1_read:   cover property (!port.wea && (port.addra[0] == 1'b1));

endmodule
